// File: cache_subsys.f
cache_pkg.sv
cache_req_decode.sv
cacheline.sv
cache_ctrl.sv
cache_mem_port.sv
cache_subsys.sv
backing_mem_model.sv
cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module cache_tb -f cache_subsys.f \
    && ./obj_dir/Vcache_tb | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

exit 0

// File: cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int DRIVE_DLY   = 2;
    localparam int ACK_TIMEOUT = 200;
    localparam int IDLE_LIMIT  = 400;
    localparam int HIT_LATENCY = 3;
    localparam int RAND_OPS    = 300;

    logic  clk;
    logic  rst;
    logic  cpu_req;
    logic  cpu_write;
    word_t cpu_addr;
    word_t cpu_wdata;
    logic  cache_en;
    logic  cpu_ack;
    word_t cpu_rdata;
    logic  cpu_hit;
    logic  mem_req;
    logic  mem_write;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_ack;
    word_t mem_rdata;
    word_t last_wr_addr;
    word_t last_wr_data;

    // reference cache and shadow memory
    tag_t  ref_tag   [LINES];
    word_t ref_data  [LINES];
    logic  ref_valid [LINES];
    idx_t  ref_ptr;
    word_t shadow_mem [tag_t];

    // expected responses in request order
    word_t exp_data_q [$];
    logic  exp_hit_q  [$];
    int    n_issued   = 0;
    int    n_checked  = 0;
    int    ack_latency;

    cache_subsys uut (
        .clk_i          (clk),
        .rst_i          (rst),
        .cpu_req_i      (cpu_req),
        .cpu_write_i    (cpu_write),
        .cpu_addr_i     (cpu_addr),
        .cpu_wdata_i    (cpu_wdata),
        .cache_enable_i (cache_en),
        .cpu_ack_o      (cpu_ack),
        .cpu_rdata_o    (cpu_rdata),
        .cpu_hit_o      (cpu_hit),
        .mem_req_o      (mem_req),
        .mem_write_o    (mem_write),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata),
        .mem_ack_i      (mem_ack),
        .mem_rdata_i    (mem_rdata)
    );

    backing_mem_model u_mem (
        .clk_i          (clk),
        .rst_i          (rst),
        .mem_req_i      (mem_req),
        .mem_write_i    (mem_write),
        .mem_addr_i     (mem_addr),
        .mem_wdata_i    (mem_wdata),
        .mem_ack_o      (mem_ack),
        .mem_rdata_o    (mem_rdata),
        .last_wr_addr_o (last_wr_addr),
        .last_wr_data_o (last_wr_data)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // reporting
    // ------------------------------------------------------------------------

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic give_up(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            stop_run();
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------

    function automatic word_t shadow_read(input tag_t key);
        if (shadow_mem.exists(key)) begin
            return shadow_mem[key];
        end
        return {2'b00, key} ^ 32'ha5a5_0000;
    endfunction

    function automatic void predict(input logic wr, input word_t addr, input word_t wdata,
                                    input logic en, output word_t exp_data,
                                    output logic exp_hit);
        tag_t key;
        logic found;
        idx_t way;
        key   = addr[31:2];
        found = 1'b0;
        way   = '0;
        for (int i = 0; i < LINES; i++) begin
            if (ref_valid[i] && ref_tag[i] == key) begin
                found = 1'b1;
                way   = idx_t'(i);
            end
        end
        if (wr) begin
            shadow_mem[key] = wdata;
            exp_data        = wdata;
            exp_hit         = en && found;
        end else if (en && found) begin
            exp_data = ref_data[way];
            exp_hit  = 1'b1;
        end else begin
            exp_data = shadow_read(key);
            exp_hit  = 1'b0;
        end
        // only cached accesses touch the lines
        if (en && found && wr) begin
            ref_data[way] = wdata;
        end else if (en && !found) begin
            ref_tag[ref_ptr]   = key;
            ref_data[ref_ptr]  = exp_data;
            ref_valid[ref_ptr] = 1'b1;
            ref_ptr            = ref_ptr + 2'd1;
        end
    endfunction

    // ------------------------------------------------------------------------
    // processor side driver
    // ------------------------------------------------------------------------

    task automatic reset_dut();
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;
        for (int i = 0; i < LINES; i++) begin
            ref_valid[i] = 1'b0;
        end
        ref_ptr = '0;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic cpu_access(input logic wr, input word_t addr, input word_t wdata,
                              input logic en, output word_t data, output logic hit);
        word_t exp_data;
        logic  exp_hit;
        int    n;
        predict(wr, addr, wdata, en, exp_data, exp_hit);
        exp_data_q.push_back(exp_data);
        exp_hit_q.push_back(exp_hit);
        n_issued++;
        cpu_write = wr;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cache_en  = en;
        cpu_req   = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
            if (n > ACK_TIMEOUT) begin
                give_up("timeout: cpu_ack_o never rose for the processor request");
            end
        end while (!cpu_ack);
        ack_latency = n;
        data        = cpu_rdata;
        hit         = cpu_hit;
        cpu_req     = 1'b0;
        n = 0;
        while (cpu_ack) begin
            @(posedge clk);
            #DRIVE_DLY;
            n++;
            if (n > ACK_TIMEOUT) begin
                give_up("timeout: cpu_ack_o never fell after the request was dropped");
            end
        end
        // decoder releases one edge after req goes low
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic access_expect_hit(input logic wr, input word_t addr, input word_t wdata,
                                     input logic en, input logic exp_hit,
                                     output word_t data);
        logic hit;
        cpu_access(wr, addr, wdata, en, data, hit);
        check_flag("cpu_hit_o", hit, exp_hit);
    endtask

    // ------------------------------------------------------------------------
    // response compare
    // ------------------------------------------------------------------------

    initial begin : compare_acks
        logic  ack_prev;
        int    idle;
        word_t exp_data;
        logic  exp_hit;
        ack_prev = 1'b0;
        idle     = 0;
        forever begin
            @(posedge clk);
            #1;
            if (cpu_ack && !ack_prev) begin
                idle = 0;
                if (exp_data_q.size() == 0) begin
                    give_up("cpu_ack_o rose with no request outstanding");
                end else begin
                    exp_data = exp_data_q.pop_front();
                    exp_hit  = exp_hit_q.pop_front();
                    check_word("cpu_rdata_o", cpu_rdata, exp_data);
                    check_flag("cpu_hit_o", cpu_hit, exp_hit);
                    n_checked++;
                end
            end else begin
                idle++;
                if (idle > IDLE_LIMIT) begin
                    give_up("timeout: no processor handshake completed for too long");
                end
            end
            ack_prev = cpu_ack;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------

    initial begin : stimulus
        word_t data;
        logic  hit;
        logic  wr;
        logic  en;
        void'($urandom(32'h3e5e));
        clk       = 1'b0;
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_write = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cache_en  = 1'b1;
        reset_dut();

        // miss then hit on one word
        access_expect_hit(1'b0, 32'h0000_1000, '0, 1'b1, 1'b0, data);
        check_word("cpu_rdata_o", data, 32'ha5a5_0400);
        access_expect_hit(1'b0, 32'h0000_1000, '0, 1'b1, 1'b1, data);
        check_word("cpu_rdata_o", data, 32'ha5a5_0400);
        check_cycles("cpu_ack_o latency", ack_latency, HIT_LATENCY);

        // fifth miss evicts the first line
        reset_dut();
        for (int i = 0; i < 5; i++) begin
            access_expect_hit(1'b0, 32'h0000_2000 + 32'(i * 4), '0, 1'b1, 1'b0, data);
        end
        access_expect_hit(1'b0, 32'h0000_2000, '0, 1'b1, 1'b0, data);
        for (int i = 2; i < 5; i++) begin
            access_expect_hit(1'b0, 32'h0000_2000 + 32'(i * 4), '0, 1'b1, 1'b1, data);
        end

        // write miss allocates and goes through
        reset_dut();
        access_expect_hit(1'b1, 32'h0000_3000, 32'h1234_5678, 1'b1, 1'b0, data);
        check_word("mem_addr_o", last_wr_addr, 32'h0000_3000);
        check_word("mem_wdata_o", last_wr_data, 32'h1234_5678);
        access_expect_hit(1'b0, 32'h0000_3000, '0, 1'b1, 1'b1, data);
        check_word("cpu_rdata_o", data, 32'h1234_5678);

        // write hit updates in place
        reset_dut();
        for (int i = 0; i < LINES; i++) begin
            access_expect_hit(1'b0, 32'h0000_4000 + 32'(i * 4), '0, 1'b1, 1'b0, data);
        end
        // pointer wrapped to line 0 so a stray fill would evict 4000
        access_expect_hit(1'b1, 32'h0000_4004, 32'hcafe_0001, 1'b1, 1'b1, data);
        check_word("mem_addr_o", last_wr_addr, 32'h0000_4004);
        check_word("mem_wdata_o", last_wr_data, 32'hcafe_0001);
        access_expect_hit(1'b0, 32'h0000_4004, '0, 1'b1, 1'b1, data);
        check_word("cpu_rdata_o", data, 32'hcafe_0001);
        access_expect_hit(1'b0, 32'h0000_4000, '0, 1'b1, 1'b1, data);
        check_word("cpu_rdata_o", data, 32'ha5a5_1000);
        for (int i = 2; i < LINES; i++) begin
            access_expect_hit(1'b0, 32'h0000_4000 + 32'(i * 4), '0, 1'b1, 1'b1, data);
        end

        // cache disabled so nothing allocates
        reset_dut();
        access_expect_hit(1'b0, 32'h0000_5000, '0, 1'b0, 1'b0, data);
        check_word("cpu_rdata_o", data, 32'ha5a5_1400);
        access_expect_hit(1'b0, 32'h0000_5000, '0, 1'b0, 1'b0, data);
        access_expect_hit(1'b1, 32'h0000_5004, 32'h0bad_f00d, 1'b0, 1'b0, data);
        check_word("mem_addr_o", last_wr_addr, 32'h0000_5004);
        check_word("mem_wdata_o", last_wr_data, 32'h0bad_f00d);
        access_expect_hit(1'b0, 32'h0000_5004, '0, 1'b0, 1'b0, data);
        check_word("cpu_rdata_o", data, 32'h0bad_f00d);
        access_expect_hit(1'b0, 32'h0000_5000, '0, 1'b1, 1'b0, data);

        // random mix over 12 words
        reset_dut();
        for (int i = 0; i < RAND_OPS; i++) begin
            wr = 1'($urandom_range(1, 0));
            en = ($urandom_range(3, 0) != 0);
            cpu_access(wr, 32'h0000_6000 + ($urandom_range(11, 0) << 2), $urandom,
                       en, data, hit);
        end

        if (n_checked == n_issued && exp_data_q.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            give_up($sformatf("only %0d of %0d responses were checked", n_checked, n_issued));
        end
    end

endmodule

`default_nettype wire

// File: backing_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module backing_mem_model (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 mem_req_i,
    input  wire logic                 mem_write_i,
    input  wire cache_pkg::word_t     mem_addr_i,
    input  wire cache_pkg::word_t     mem_wdata_i,
    output logic                      mem_ack_o,
    output cache_pkg::word_t          mem_rdata_o,
    output cache_pkg::word_t          last_wr_addr_o,
    output cache_pkg::word_t          last_wr_data_o
);
    import cache_pkg::*;

    // sparse store keyed by word address
    word_t       mem_q [tag_t];
    logic        busy_q;
    int unsigned wait_q;

    // unwritten words read back as their own word address, scrambled
    function automatic word_t read_word(input tag_t key);
        if (mem_q.exists(key)) begin
            return mem_q[key];
        end
        return {2'b00, key} ^ 32'ha5a5_0000;
    endfunction

    always @(posedge clk_i) begin
        if (rst_i) begin
            mem_ack_o <= 1'b0;
            busy_q    <= 1'b0;
            wait_q    <= 0;
        end else if (mem_ack_o) begin
            // phase 4, release once req is gone
            if (!mem_req_i) begin
                mem_ack_o <= 1'b0;
            end
        end else if (busy_q) begin
            if (wait_q == 0) begin
                busy_q    <= 1'b0;
                mem_ack_o <= 1'b1;
                if (mem_write_i) begin
                    mem_q[mem_addr_i[31:2]] = mem_wdata_i;
                    last_wr_addr_o <= mem_addr_i;
                    last_wr_data_o <= mem_wdata_i;
                    mem_rdata_o    <= mem_wdata_i;
                end else begin
                    mem_rdata_o <= read_word(mem_addr_i[31:2]);
                end
            end else begin
                wait_q <= wait_q - 1;
            end
        end else if (mem_req_i) begin
            // answer 1 to 5 cycles after req is seen
            busy_q <= 1'b1;
            wait_q <= $urandom_range(5, 1) - 1;
        end
    end

endmodule

`default_nettype wire

// File: cache_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsys (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    // processor side
    input  wire logic                 cpu_req_i,
    input  wire logic                 cpu_write_i,
    input  wire cache_pkg::word_t     cpu_addr_i,
    input  wire cache_pkg::word_t     cpu_wdata_i,
    input  wire logic                 cache_enable_i,
    output logic                      cpu_ack_o,
    output cache_pkg::word_t          cpu_rdata_o,
    output logic                      cpu_hit_o,
    // backing memory side
    output logic                      mem_req_o,
    output logic                      mem_write_o,
    output cache_pkg::word_t          mem_addr_o,
    output cache_pkg::word_t          mem_wdata_o,
    input  wire logic                 mem_ack_i,
    input  wire cache_pkg::word_t     mem_rdata_i
);
    import cache_pkg::*;

    // decode to execute
    logic      dec_valid;
    cache_op_e dec_op;
    tag_t      dec_tag;
    word_t     dec_addr;
    word_t     dec_wdata;
    logic      dec_cached;
    logic      dec_done;

    // tag store
    logic      hit;
    word_t     hit_data;
    logic      fill_en;
    word_t     fill_data;
    logic      upd_en;
    word_t     upd_data;

    // memory port
    logic      mp_start;
    logic      mp_write;
    word_t     mp_addr;
    word_t     mp_wdata;
    logic      mp_done;
    word_t     mp_rdata;

    cache_req_decode u_decode (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_write_i    (cpu_write_i),
        .cpu_addr_i     (cpu_addr_i),
        .cpu_wdata_i    (cpu_wdata_i),
        .cache_enable_i (cache_enable_i),
        .dec_done_i     (dec_done),
        .dec_valid_o    (dec_valid),
        .dec_op_o       (dec_op),
        .dec_tag_o      (dec_tag),
        .dec_addr_o     (dec_addr),
        .dec_wdata_o    (dec_wdata),
        .dec_cached_o   (dec_cached)
    );

    cache_ctrl u_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .dec_valid_i  (dec_valid),
        .dec_op_i     (dec_op),
        .dec_addr_i   (dec_addr),
        .dec_wdata_i  (dec_wdata),
        .dec_cached_i (dec_cached),
        .dec_done_o   (dec_done),
        .hit_i        (hit),
        .hit_data_i   (hit_data),
        .fill_en_o    (fill_en),
        .fill_data_o  (fill_data),
        .upd_en_o     (upd_en),
        .upd_data_o   (upd_data),
        .mp_start_o   (mp_start),
        .mp_write_o   (mp_write),
        .mp_addr_o    (mp_addr),
        .mp_wdata_o   (mp_wdata),
        .mp_done_i    (mp_done),
        .mp_rdata_i   (mp_rdata),
        .cpu_req_i    (cpu_req_i),
        .cpu_ack_o    (cpu_ack_o),
        .cpu_rdata_o  (cpu_rdata_o),
        .cpu_hit_o    (cpu_hit_o)
    );

    // lookup runs straight off the decoded tag
    cacheline u_cacheline (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .lookup_tag_i (dec_tag),
        .hit_o        (hit),
        .hit_data_o   (hit_data),
        .fill_en_i    (fill_en),
        .fill_data_i  (fill_data),
        .upd_en_i     (upd_en),
        .upd_data_i   (upd_data)
    );

    cache_mem_port u_mem_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mp_start_i  (mp_start),
        .mp_write_i  (mp_write),
        .mp_addr_i   (mp_addr),
        .mp_wdata_i  (mp_wdata),
        .mp_done_o   (mp_done),
        .mp_rdata_o  (mp_rdata),
        .mem_req_o   (mem_req_o),
        .mem_write_o (mem_write_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

`default_nettype wire

// File: cache_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module cache_mem_port (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 mp_start_i,
    input  wire logic                 mp_write_i,
    input  wire cache_pkg::word_t     mp_addr_i,
    input  wire cache_pkg::word_t     mp_wdata_i,
    output logic                      mp_done_o,
    output cache_pkg::word_t          mp_rdata_o,
    output logic                      mem_req_o,
    output logic                      mem_write_o,
    output cache_pkg::word_t          mem_addr_o,
    output cache_pkg::word_t          mem_wdata_o,
    input  wire logic                 mem_ack_i,
    input  wire cache_pkg::word_t     mem_rdata_i
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_REQ,
        P_DROP
    } port_state_e;

    port_state_e state_q;

    // ------------------------------------------------------------------------
    // four-phase master
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= P_IDLE;
            mem_req_o <= 1'b0;
            mp_done_o <= 1'b0;
        end else begin
            mp_done_o <= 1'b0;
            case (state_q)
                P_IDLE: begin
                    if (mp_start_i) begin
                        state_q   <= P_REQ;
                        mem_req_o <= 1'b1;
                    end
                end
                // phase 2, slave acknowledged
                P_REQ: begin
                    if (mem_ack_i) begin
                        state_q   <= P_DROP;
                        mem_req_o <= 1'b0;
                        mp_done_o <= 1'b1;
                    end
                end
                // phase 4, no new start until ack is gone
                P_DROP: begin
                    if (!mem_ack_i) begin
                        state_q <= P_IDLE;
                    end
                end
                default: state_q <= P_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // request fields and returned word
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (state_q == P_IDLE && mp_start_i) begin
            mem_write_o <= mp_write_i;
            mem_addr_o  <= mp_addr_i;
            mem_wdata_o <= mp_wdata_i;
        end
        // rdata only valid while ack is high
        if (state_q == P_REQ && mem_ack_i) begin
            mp_rdata_o <= mem_rdata_i;
        end
    end

endmodule

`default_nettype wire

// File: cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 dec_valid_i,
    input  wire cache_pkg::cache_op_e dec_op_i,
    input  wire cache_pkg::word_t     dec_addr_i,
    input  wire cache_pkg::word_t     dec_wdata_i,
    input  wire logic                 dec_cached_i,
    output logic                      dec_done_o,
    input  wire logic                 hit_i,
    input  wire cache_pkg::word_t     hit_data_i,
    output logic                      fill_en_o,
    output cache_pkg::word_t          fill_data_o,
    output logic                      upd_en_o,
    output cache_pkg::word_t          upd_data_o,
    output logic                      mp_start_o,
    output logic                      mp_write_o,
    output cache_pkg::word_t          mp_addr_o,
    output cache_pkg::word_t          mp_wdata_o,
    input  wire logic                 mp_done_i,
    input  wire cache_pkg::word_t     mp_rdata_i,
    input  wire logic                 cpu_req_i,
    output logic                      cpu_ack_o,
    output cache_pkg::word_t          cpu_rdata_o,
    output logic                      cpu_hit_o
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_DISPATCH,
        S_MEM,
        S_ACK
    } ctrl_state_e;

    ctrl_state_e state_q;

    // lookup result registered on accept
    logic  hit_q;
    word_t line_q;
    logic  is_wr;
    logic  rd_hit;
    logic  mem_end;

    assign is_wr   = (dec_op_i == OP_WR);
    assign rd_hit  = (dec_op_i == OP_RD) && hit_q;
    assign mem_end = (state_q == S_MEM) && mp_done_i;

    // ------------------------------------------------------------------------
    // sequencer
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            cpu_ack_o <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (dec_valid_i) begin
                        state_q <= S_DISPATCH;
                    end
                end
                S_DISPATCH: begin
                    if (rd_hit) begin
                        state_q   <= S_ACK;
                        cpu_ack_o <= 1'b1;
                    end else begin
                        state_q <= S_MEM;
                    end
                end
                // fill or update happens on the same edge
                S_MEM: begin
                    if (mp_done_i) begin
                        state_q   <= S_ACK;
                        cpu_ack_o <= 1'b1;
                    end
                end
                S_ACK: begin
                    if (!cpu_req_i) begin
                        state_q   <= S_IDLE;
                        cpu_ack_o <= 1'b0;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // lookup capture and response payload
    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && dec_valid_i) begin
            hit_q  <= hit_i;
            line_q <= hit_data_i;
        end
        if (state_q == S_DISPATCH && rd_hit) begin
            cpu_rdata_o <= line_q;
            cpu_hit_o   <= 1'b1;
        end else if (mem_end) begin
            // writes echo the stored word back
            cpu_rdata_o <= is_wr ? dec_wdata_i : mp_rdata_i;
            cpu_hit_o   <= is_wr && dec_cached_i && hit_q;
        end
    end

    // ------------------------------------------------------------------------
    // cacheline and memory port controls
    // ------------------------------------------------------------------------

    // refill on a cached miss of either kind
    assign fill_en_o   = mem_end && dec_cached_i && !hit_q && (dec_op_i != OP_RD_NC);
    assign fill_data_o = is_wr ? dec_wdata_i : mp_rdata_i;

    assign upd_en_o    = mem_end && is_wr && dec_cached_i && hit_q;
    assign upd_data_o  = dec_wdata_i;

    // level request, the port ignores it while busy
    assign mp_start_o  = (state_q == S_MEM);
    assign mp_write_o  = is_wr;
    assign mp_addr_o   = dec_addr_i;
    assign mp_wdata_o  = dec_wdata_i;

    assign dec_done_o  = (state_q == S_ACK) && !cpu_req_i;

endmodule

`default_nettype wire

// File: cacheline.sv
`timescale 1ns/1ps
`default_nettype none

module cacheline (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire cache_pkg::tag_t      lookup_tag_i,
    output logic                      hit_o,
    output cache_pkg::word_t          hit_data_o,
    input  wire logic                 fill_en_i,
    input  wire cache_pkg::word_t     fill_data_i,
    input  wire logic                 upd_en_i,
    input  wire cache_pkg::word_t     upd_data_i
);
    import cache_pkg::*;

    // ------------------------------------------------------------------------
    // line storage
    // ------------------------------------------------------------------------

    tag_t  tag_q   [LINES];
    word_t data_q  [LINES];
    logic  valid_q [LINES];

    // next line to replace
    idx_t  fifo_ptr_q;

    logic [LINES-1:0] match;

    // ------------------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------------------

    // all lines compared in parallel, valid required
    always_comb begin
        for (int i = 0; i < LINES; i++) begin
            match[i] = valid_q[i] && (tag_q[i] == lookup_tag_i);
        end
    end

    assign hit_o = |match;

    // at most one line can match, so an and-or select is enough
    always_comb begin
        hit_data_o = '0;
        for (int i = 0; i < LINES; i++) begin
            if (match[i]) begin
                hit_data_o = hit_data_o | data_q[i];
            end
        end
    end

    // ------------------------------------------------------------------------
    // allocation and update
    // ------------------------------------------------------------------------

    // valid bits and replacement pointer
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            fifo_ptr_q <= '0;
            for (int i = 0; i < LINES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (fill_en_i) begin
            valid_q[fifo_ptr_q] <= 1'b1;
            fifo_ptr_q          <= fifo_ptr_q + 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk_i) begin
        if (fill_en_i) begin
            tag_q[fifo_ptr_q]  <= lookup_tag_i;
            data_q[fifo_ptr_q] <= fill_data_i;
        end else if (upd_en_i) begin
            // write hit, rewrite the matching word in place
            for (int i = 0; i < LINES; i++) begin
                if (match[i]) begin
                    data_q[i] <= upd_data_i;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_req_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cache_req_decode (
    input  wire logic                 clk_i,
    input  wire logic                 rst_i,
    input  wire logic                 cpu_req_i,
    input  wire logic                 cpu_write_i,
    input  wire cache_pkg::word_t     cpu_addr_i,
    input  wire cache_pkg::word_t     cpu_wdata_i,
    input  wire logic                 cache_enable_i,
    input  wire logic                 dec_done_i,
    output logic                      dec_valid_o,
    output cache_pkg::cache_op_e      dec_op_o,
    output cache_pkg::tag_t           dec_tag_o,
    output cache_pkg::word_t          dec_addr_o,
    output cache_pkg::word_t          dec_wdata_o,
    output logic                      dec_cached_o
);
    import cache_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_BUSY,
        D_RELEASE
    } dec_state_e;

    dec_state_e state_q;

    // handshake tracking
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= D_IDLE;
        end else begin
            case (state_q)
                D_IDLE: begin
                    if (cpu_req_i) begin
                        state_q <= D_BUSY;
                    end
                end
                D_BUSY: begin
                    if (dec_done_i) begin
                        state_q <= D_RELEASE;
                    end
                end
                // req must go low before the next capture
                D_RELEASE: begin
                    if (!cpu_req_i) begin
                        state_q <= D_IDLE;
                    end
                end
                default: state_q <= D_IDLE;
            endcase
        end
    end

    // request fields, held until the controller is done
    always_ff @(posedge clk_i) begin
        if (state_q == D_IDLE && cpu_req_i) begin
            if (cpu_write_i) begin
                dec_op_o <= OP_WR;
            end else if (cache_enable_i) begin
                dec_op_o <= OP_RD;
            end else begin
                dec_op_o <= OP_RD_NC;
            end
            dec_tag_o    <= cpu_addr_i[ADDR_W-1:ADDR_W-TAG_W];
            dec_addr_o   <= cpu_addr_i;
            dec_wdata_o  <= cpu_wdata_i;
            dec_cached_o <= cache_enable_i;
        end
    end

    assign dec_valid_o = (state_q == D_BUSY);

endmodule

`default_nettype wire

// File: cache_pkg.sv
`default_nettype none

package cache_pkg;

    // ------------------------------------------------------------------------
    // widths and geometry
    // ------------------------------------------------------------------------

    // processor data word
    localparam int DATA_W = 32;
    // byte address from the processor
    localparam int ADDR_W = 32;
    // word address, byte offset stripped
    localparam int TAG_W  = 30;

    // fully associative, one word per line
    localparam int LINES  = 4;
    localparam int IDX_W  = 2;

    // ------------------------------------------------------------------------
    // shared types
    // ------------------------------------------------------------------------

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [TAG_W-1:0]  tag_t;

    // round-robin replacement pointer
    typedef logic [IDX_W-1:0]  idx_t;

    // request kind as seen by the execute stage
    typedef enum logic [1:0] {
        OP_RD    = 2'd0,
        OP_WR    = 2'd1,
        OP_RD_NC = 2'd2
    } cache_op_e;

endpackage

`default_nettype wire
